// File: src/basic_cpu_pkg.sv
package basic_cpu_pkg;

    localparam int word_w = 16;
    localparam int addr_w = 12;

    typedef logic [word_w-1:0] word_t;
    typedef logic [addr_w-1:0] addr_t;

    // Opcode field IR[14:12]
    typedef enum logic [2:0] {
        op_and    = 3'd0,
        op_add    = 3'd1,
        op_lda    = 3'd2,
        op_sta    = 3'd3,
        op_bun    = 3'd4,
        op_bsa    = 3'd5,
        op_isz    = 3'd6,
        op_reg_io = 3'd7
    } mem_op_e;

    // Register-reference ops, reg_cla is IR[11] down to reg_hlt at IR[0]
    typedef enum logic [3:0] {
        reg_none, reg_cla, reg_cle, reg_cma, reg_cme, reg_cir, reg_cil,
        reg_inc, reg_spa, reg_sna, reg_sza, reg_sze, reg_hlt
    } reg_op_e;

    // Common bus sources
    typedef enum logic [2:0] {
        bus_none, bus_ar, bus_pc, bus_dr, bus_ac, bus_ir, bus_mem
    } bus_src_e;

    // Accumulator and E operations
    typedef enum logic [3:0] {
        alu_hold,
        alu_and,
        alu_add,
        alu_load,
        alu_clear,
        alu_compl,
        alu_shr,
        alu_shl,
        alu_inc,
        alu_e_clear,
        alu_e_compl
    } alu_op_e;

endpackage

// File: src/control_sequencer.sv
`timescale 1ns/1ps

module control_sequencer
    import basic_cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  word_t    ir,
    input  word_t    dr,
    input  word_t    ac,
    input  logic     e,
    output logic     busy,
    output bus_src_e bus_src,
    output logic     ar_load,
    output logic     ar_inc,
    output logic     pc_load,
    output logic     pc_inc,
    output logic     dr_load,
    output logic     dr_inc,
    output logic     ir_load,
    output alu_op_e  alu_op,
    output logic     mem_we
);

    logic [2:0] sc;
    logic       i_bit;
    logic       sc_clr;
    logic       halt;
    logic       skip;
    mem_op_e    opcode;
    reg_op_e    reg_op;

    assign opcode = mem_op_e'(ir[14:12]);

    // Highest set bit of IR[11:0] wins
    always_comb begin
        reg_op = reg_none;
        for (int i = 0; i < addr_w; i++) begin
            if (ir[i]) begin
                reg_op = reg_op_e'(4'(addr_w - i));
            end
        end
    end

    always_comb begin
        case (reg_op)
            reg_spa: skip = ~ac[word_w-1];
            reg_sna: skip = ac[word_w-1];
            reg_sza: skip = (ac == '0);
            reg_sze: skip = ~e;
            default: skip = 1'b0;
        endcase
    end

    always_comb begin
        bus_src = bus_none;
        ar_load = 1'b0;
        ar_inc  = 1'b0;
        pc_load = 1'b0;
        pc_inc  = 1'b0;
        dr_load = 1'b0;
        dr_inc  = 1'b0;
        ir_load = 1'b0;
        alu_op  = alu_hold;
        mem_we  = 1'b0;
        sc_clr  = 1'b0;
        halt    = 1'b0;
        if (busy) begin
            case (sc)
                3'd0: begin
                    bus_src = bus_pc;
                    ar_load = 1'b1;
                end
                3'd1: begin
                    bus_src = bus_mem;
                    ir_load = 1'b1;
                    pc_inc  = 1'b1;
                end
                3'd2: begin
                    bus_src = bus_ir;
                    ar_load = 1'b1;
                end
                3'd3: begin
                    if (opcode != op_reg_io) begin
                        // Indirect step, direct operands just wait here
                        if (i_bit) begin
                            bus_src = bus_mem;
                            ar_load = 1'b1;
                        end
                    end else begin
                        sc_clr = 1'b1;
                        // I/O-type words fall through as a no-op
                        if (!i_bit) begin
                            pc_inc = skip;
                            halt   = (reg_op == reg_hlt);
                            case (reg_op)
                                reg_cla: alu_op = alu_clear;
                                reg_cle: alu_op = alu_e_clear;
                                reg_cma: alu_op = alu_compl;
                                reg_cme: alu_op = alu_e_compl;
                                reg_cir: alu_op = alu_shr;
                                reg_cil: alu_op = alu_shl;
                                reg_inc: alu_op = alu_inc;
                                default: alu_op = alu_hold;
                            endcase
                        end
                    end
                end
                3'd4: begin
                    case (opcode)
                        op_and, op_add, op_lda, op_isz: begin
                            bus_src = bus_mem;
                            dr_load = 1'b1;
                        end
                        op_sta: begin
                            bus_src = bus_ac;
                            mem_we  = 1'b1;
                            sc_clr  = 1'b1;
                        end
                        op_bun: begin
                            bus_src = bus_ar;
                            pc_load = 1'b1;
                            sc_clr  = 1'b1;
                        end
                        op_bsa: begin
                            // Return address goes to M[AR]
                            bus_src = bus_pc;
                            mem_we  = 1'b1;
                            ar_inc  = 1'b1;
                        end
                        default: sc_clr = 1'b1;
                    endcase
                end
                3'd5: begin
                    case (opcode)
                        op_and: alu_op = alu_and;
                        op_add: alu_op = alu_add;
                        op_lda: alu_op = alu_load;
                        op_bsa: begin
                            bus_src = bus_ar;
                            pc_load = 1'b1;
                        end
                        op_isz: dr_inc = 1'b1;
                        default: alu_op = alu_hold;
                    endcase
                    sc_clr = (opcode != op_isz);
                end
                3'd6: begin
                    // ISZ write back, skip on the wrapped count
                    bus_src = bus_dr;
                    mem_we  = 1'b1;
                    pc_inc  = (dr == '0);
                    sc_clr  = 1'b1;
                end
                default: sc_clr = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            sc    <= '0;
            i_bit <= 1'b0;
        end else if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                sc   <= '0;
            end
        end else begin
            if (halt) begin
                busy <= 1'b0;
            end
            if (sc_clr) begin
                sc <= '0;
            end else begin
                sc <= sc + 3'd1;
            end
            if (sc == 3'd2) begin
                i_bit <= ir[word_w-1];
            end
        end
    end

endmodule

// File: src/cpu_registers.sv
`timescale 1ns/1ps

module cpu_registers
    import basic_cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  bus_src_e bus_src,
    input  logic     ar_load,
    input  logic     ar_inc,
    input  logic     pc_load,
    input  logic     pc_inc,
    input  logic     dr_load,
    input  logic     dr_inc,
    input  logic     ir_load,
    input  word_t    ac,
    input  word_t    mem_rdata,
    output word_t    bus,
    output addr_t    ar,
    output addr_t    pc,
    output word_t    dr,
    output word_t    ir
);

    // Common bus, address registers zero-extended
    always_comb begin
        case (bus_src)
            bus_ar:  bus = word_t'(ar);
            bus_pc:  bus = word_t'(pc);
            bus_dr:  bus = dr;
            bus_ac:  bus = ac;
            bus_ir:  bus = ir;
            bus_mem: bus = mem_rdata;
            default: bus = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ar <= '0;
            pc <= '0;
            ir <= '0;
        end else begin
            if (ar_load) begin
                ar <= bus[addr_w-1:0];
            end else if (ar_inc) begin
                ar <= ar + 1'b1;
            end
            if (pc_load) begin
                pc <= bus[addr_w-1:0];
            end else if (pc_inc) begin
                pc <= pc + 1'b1;
            end
            if (ir_load) begin
                ir <= bus;
            end
        end
    end

    // Operand register
    always_ff @(posedge clk) begin
        if (dr_load) begin
            dr <= bus;
        end else if (dr_inc) begin
            dr <= dr + 1'b1;
        end
    end

endmodule

// File: src/accumulator_unit.sv
`timescale 1ns/1ps

module accumulator_unit
    import basic_cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  alu_op_e alu_op,
    input  word_t   dr,
    output word_t   ac,
    output logic    e
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ac <= '0;
            e  <= 1'b0;
        end else begin
            case (alu_op)
                alu_and: begin
                    ac <= ac & dr;
                end
                alu_add: begin
                    // Carry out lands in E
                    {e, ac} <= {1'b0, ac} + {1'b0, dr};
                end
                alu_load: begin
                    ac <= dr;
                end
                alu_clear: begin
                    ac <= '0;
                end
                alu_compl: begin
                    ac <= ~ac;
                end
                alu_shr: begin
                    // Rotate right through E
                    {ac, e} <= {e, ac};
                end
                alu_shl: begin
                    {e, ac} <= {ac, e};
                end
                alu_inc: begin
                    ac <= ac + 1'b1;
                end
                alu_e_clear: begin
                    e <= 1'b0;
                end
                alu_e_compl: begin
                    e <= ~e;
                end
                default: begin
                    ac <= ac;
                end
            endcase
        end
    end

endmodule

// File: src/memory_arbiter.sv
`timescale 1ns/1ps

module memory_arbiter
    import basic_cpu_pkg::*;
#(
    parameter int mem_addr_w = 8
) (
    input  logic                  busy,
    input  addr_t                 cpu_addr,
    input  logic                  cpu_we,
    input  word_t                 cpu_wdata,
    input  logic                  host_we,
    input  logic [mem_addr_w-1:0] host_addr,
    input  word_t                 host_wdata,
    output logic [mem_addr_w-1:0] mem_addr,
    output logic                  mem_we,
    output word_t                 mem_wdata
);

    // Processor owns the port while running, host writes are dropped then
    always_comb begin
        if (busy) begin
            mem_addr  = cpu_addr[mem_addr_w-1:0];
            mem_we    = cpu_we;
            mem_wdata = cpu_wdata;
        end else begin
            mem_addr  = host_addr;
            mem_we    = host_we;
            mem_wdata = host_wdata;
        end
    end

endmodule

// File: src/main_memory.sv
`timescale 1ns/1ps

module main_memory
    import basic_cpu_pkg::*;
#(
    parameter int mem_addr_w = 8
) (
    input  logic                  clk,
    input  logic [mem_addr_w-1:0] addr,
    input  logic                  we,
    input  word_t                 wdata,
    output word_t                 rdata
);

    word_t mem [2**mem_addr_w];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Asynchronous read port
    assign rdata = mem[addr];

endmodule

// File: src/basic_cpu.sv
`timescale 1ns/1ps

module basic_cpu
    import basic_cpu_pkg::*;
#(
    parameter int mem_addr_w = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  host_we,
    input  logic [mem_addr_w-1:0] host_addr,
    input  word_t                 host_wdata,
    output word_t                 host_rdata,
    output logic                  busy,
    output word_t                 ac,
    output logic                  e,
    output addr_t                 pc
);

    bus_src_e              bus_src;
    alu_op_e               alu_op;
    logic                  ar_load;
    logic                  ar_inc;
    logic                  pc_load;
    logic                  pc_inc;
    logic                  dr_load;
    logic                  dr_inc;
    logic                  ir_load;
    logic                  cpu_we;
    word_t                 bus;
    addr_t                 ar;
    word_t                 dr;
    word_t                 ir;
    logic [mem_addr_w-1:0] mem_addr;
    logic                  mem_we;
    word_t                 mem_wdata;

    control_sequencer i_control_sequencer (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .ir      (ir),
        .dr      (dr),
        .ac      (ac),
        .e       (e),
        .busy    (busy),
        .bus_src (bus_src),
        .ar_load (ar_load),
        .ar_inc  (ar_inc),
        .pc_load (pc_load),
        .pc_inc  (pc_inc),
        .dr_load (dr_load),
        .dr_inc  (dr_inc),
        .ir_load (ir_load),
        .alu_op  (alu_op),
        .mem_we  (cpu_we)
    );

    cpu_registers i_cpu_registers (
        .clk       (clk),
        .rst       (rst),
        .bus_src   (bus_src),
        .ar_load   (ar_load),
        .ar_inc    (ar_inc),
        .pc_load   (pc_load),
        .pc_inc    (pc_inc),
        .dr_load   (dr_load),
        .dr_inc    (dr_inc),
        .ir_load   (ir_load),
        .ac        (ac),
        .mem_rdata (host_rdata),
        .bus       (bus),
        .ar        (ar),
        .pc        (pc),
        .dr        (dr),
        .ir        (ir)
    );

    accumulator_unit i_accumulator_unit (
        .clk    (clk),
        .rst    (rst),
        .alu_op (alu_op),
        .dr     (dr),
        .ac     (ac),
        .e      (e)
    );

    memory_arbiter #(
        .mem_addr_w (mem_addr_w)
    ) i_memory_arbiter (
        .busy       (busy),
        .cpu_addr   (ar),
        .cpu_we     (cpu_we),
        .cpu_wdata  (bus),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .mem_addr   (mem_addr),
        .mem_we     (mem_we),
        .mem_wdata  (mem_wdata)
    );

    // Read data serves both the host port and the bus
    main_memory #(
        .mem_addr_w (mem_addr_w)
    ) i_main_memory (
        .clk   (clk),
        .addr  (mem_addr),
        .we    (mem_we),
        .wdata (mem_wdata),
        .rdata (host_rdata)
    );

endmodule

// File: verification/tb_isa_model.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// 16-bit Galois LFSR stepped once per bit taken
function automatic logic lfsr_step();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
        lfsr_state = lfsr_state ^ 16'hB400;
    end
    return lsb;
endfunction

function automatic word_t rand_word();
    word_t w;
    w = '0;
    for (int i = 0; i < word_w; i++) begin
        w = {w[word_w-2:0], lfsr_step()};
    end
    return w;
endfunction

function automatic void place_word(input int addr, input word_t w);
    model_mem[addr % mem_depth] = w;
endfunction

// Memory-reference encoding {I, opcode, address}
function automatic word_t mri(input logic ind, input logic [2:0] op, input int addr);
    return {ind, op, 12'(addr)};
endfunction

// Arithmetic program with operands at base+0x40
function automatic void build_arith(input int base);
    int d;
    d = base + 'h40;
    for (int i = 0; i < 4; i++) begin
        place_word(d + i, rand_word());
    end
    place_word(d + 4, word_t'(d + 5));
    place_word(d + 5, rand_word());
    place_word(d + 6, word_t'(d + 3));
    place_word(d + 10, word_t'(d + 11));
    place_word(base + 0, mri(1'b0, 3'd2, d + 0));
    place_word(base + 1, mri(1'b0, 3'd1, d + 1));
    place_word(base + 2, mri(1'b0, 3'd3, d + 8));
    place_word(base + 3, mri(1'b1, 3'd0, d + 4));
    place_word(base + 4, mri(1'b1, 3'd1, d + 6));
    place_word(base + 5, mri(1'b1, 3'd3, d + 10));
    place_word(base + 6, mri(1'b0, 3'd1, d + 3));
    place_word(base + 7, mri(1'b0, 3'd3, d + 9));
    place_word(base + 8, 16'h7001);
endfunction

// Subroutine call, ISZ loop and indirect branch
function automatic void build_flow(input int base);
    int d;
    int s;
    d = base + 'h40;
    s = base + 'h30;
    place_word(d + 0, 16'hFFFD);
    place_word(d + 1, word_t'(base + 5));
    place_word(d + 2, rand_word());
    place_word(base + 0, mri(1'b0, 3'd5, s));
    place_word(base + 1, mri(1'b0, 3'd6, d + 0));
    place_word(base + 2, mri(1'b0, 3'd4, base + 1));
    place_word(base + 3, mri(1'b1, 3'd4, d + 1));
    place_word(base + 4, 16'h7001);
    place_word(base + 5, mri(1'b0, 3'd2, d + 2));
    place_word(base + 6, 16'h7001);
    place_word(s + 0, 16'h0000);
    place_word(s + 1, 16'h7200);
    place_word(s + 2, mri(1'b1, 3'd4, s));
endfunction

// Register-reference words with each skip followed by an INC
// Rotate results are stored at base+0x41 and base+0x42
function automatic void build_regref(input int base);
    word_t code[$];
    code = {16'h7200, 16'h7080, 16'h7040, 16'h7100, 16'h7080, 16'h7020,
            16'hF800, mri(1'b0, 3'd3, base + 'h41), 16'h7040,
            mri(1'b0, 3'd3, base + 'h42),
            16'h7800, 16'h7400, 16'h7004, 16'h7020, 16'h7002, 16'h7020,
            16'h7100, 16'h7002, 16'h7020, 16'h7010, 16'h7020, 16'h7200,
            16'h7008, 16'h7020, 16'h7010, 16'h7020, 16'h7800, 16'h7008,
            16'h7020, 16'h7004, 16'h7020, 16'h7040, 16'h7001};
    place_word(base + 'h40, rand_word());
    place_word(base, mri(1'b0, 3'd2, base + 'h40));
    foreach (code[i]) begin
        place_word(base + 1 + i, code[i]);
    end
endfunction

// Runs from m_pc until HLT and returns the cycle count
function automatic int run_model();
    int cyc;
    int steps;
    int sum;
    logic old_e;
    logic run;
    word_t ir;
    word_t dr;
    addr_t ar;
    cyc = 0;
    steps = 0;
    run = 1'b1;
    while (run && steps < 1000) begin
        steps++;
        ir = model_mem[m_pc % mem_depth];
        m_pc = m_pc + 12'd1;
        ar = ir[11:0];
        if (ir[14:12] == 3'd7) begin
            cyc += 4;
            if (!ir[15]) begin
                if (ir[11]) m_ac = '0;
                else if (ir[10]) m_e = 1'b0;
                else if (ir[9]) m_ac = ~m_ac;
                else if (ir[8]) m_e = ~m_e;
                else if (ir[7]) begin
                    old_e = m_e;
                    m_e = m_ac[0];
                    m_ac = {old_e, m_ac[15:1]};
                end
                else if (ir[6]) begin
                    old_e = m_e;
                    m_e = m_ac[15];
                    m_ac = {m_ac[14:0], old_e};
                end
                else if (ir[5]) m_ac = m_ac + 16'd1;
                else if (ir[4]) m_pc = m_pc + 12'(!m_ac[15]);
                else if (ir[3]) m_pc = m_pc + 12'(m_ac[15]);
                else if (ir[2]) m_pc = m_pc + 12'(m_ac == '0);
                else if (ir[1]) m_pc = m_pc + 12'(!m_e);
                else if (ir[0]) run = 1'b0;
            end
        end else begin
            if (ir[15]) begin
                ar = model_mem[ar % mem_depth][11:0];
            end
            case (ir[14:12])
                3'd0: begin
                    m_ac = m_ac & model_mem[ar % mem_depth];
                    cyc += 6;
                end
                3'd1: begin
                    sum = int'(m_ac) + int'(model_mem[ar % mem_depth]);
                    m_ac = word_t'(sum);
                    m_e = (sum > 'hFFFF);
                    cyc += 6;
                end
                3'd2: begin
                    m_ac = model_mem[ar % mem_depth];
                    cyc += 6;
                end
                3'd3: begin
                    model_mem[ar % mem_depth] = m_ac;
                    cyc += 5;
                end
                3'd4: begin
                    m_pc = ar;
                    cyc += 5;
                end
                3'd5: begin
                    model_mem[ar % mem_depth] = word_t'(m_pc);
                    m_pc = ar + 12'd1;
                    cyc += 6;
                end
                default: begin
                    dr = model_mem[ar % mem_depth] + 16'd1;
                    model_mem[ar % mem_depth] = dr;
                    if (dr == '0) m_pc = m_pc + 12'd1;
                    cyc += 7;
                end
            endcase
        end
    end
    return cyc;
endfunction

`endif

// File: verification/tb_basic_cpu.sv
`timescale 1ns/1ps

module tb_basic_cpu;
    import basic_cpu_pkg::*;

    localparam int mem_addr_w = 8;
    localparam int mem_depth = 2 ** mem_addr_w;
    localparam int n_programs = 4;
    localparam int max_instr = 64;
    localparam int limit_cycles = 16 + 4 * mem_depth
        + n_programs * (max_instr * 7 + 4 * mem_depth) + 500;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  host_we;
    logic [mem_addr_w-1:0] host_addr;
    word_t                 host_wdata;
    word_t                 host_rdata;
    logic                  busy;
    word_t                 ac;
    logic                  e;
    addr_t                 pc;

    // Reference state
    word_t      model_mem [mem_depth];
    word_t      m_ac;
    logic       m_e;
    addr_t      m_pc;
    logic [15:0] lfsr_state;
    int         exp_cycles;
    int         busy_cycles;
    int         errors;
    int         checks;
    event       prog_started;
    event       prog_checked;

    `include "tb_isa_model.svh"

    basic_cpu #(
        .mem_addr_w (mem_addr_w)
    ) i_basic_cpu (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .busy       (busy),
        .ac         (ac),
        .e          (e),
        .pc         (pc)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic load_memory();
        for (int a = 0; a < mem_depth; a++) begin
            @(negedge clk);
            host_we    = 1'b1;
            host_addr  = mem_addr_w'(a);
            host_wdata = model_mem[a];
        end
        @(negedge clk);
        host_we = 1'b0;
    endtask

    task automatic verify_memory();
        for (int a = 0; a < mem_depth; a++) begin
            @(negedge clk);
            host_addr = mem_addr_w'(a);
            @(posedge clk);
            check_word($sformatf("mem[%0d]", a), model_mem[a], host_rdata);
        end
    endtask

    // Loads, runs the model, pulses start and waits for the compare
    task automatic launch(input bit disturb, input int spare);
        load_memory();
        exp_cycles = run_model();
        @(negedge clk);
        start = 1'b1;
        -> prog_started;
        @(negedge clk);
        start = 1'b0;
        if (disturb) begin
            repeat (2) @(negedge clk);
            start      = 1'b1;
            host_we    = 1'b1;
            host_addr  = mem_addr_w'(spare);
            host_wdata = ~model_mem[spare % mem_depth];
            @(negedge clk);
            start   = 1'b0;
            host_we = 1'b0;
        end
        @(prog_checked);
    endtask

    // Compare after each halt
    initial begin
        forever begin
            @(prog_started);
            busy_cycles = 0;
            @(negedge clk);
            while (busy) begin
                busy_cycles++;
                @(negedge clk);
            end
            check_word("busy_cycles", word_t'(exp_cycles), word_t'(busy_cycles));
            check_word("ac", m_ac, ac);
            check_word("e", word_t'(m_e), word_t'(e));
            check_word("pc", word_t'(m_pc), word_t'(pc));
            verify_memory();
            -> prog_checked;
        end
    end

    initial begin
        #(limit_cycles * 40);
        $display("Timeout, the machine did not halt in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        lfsr_state = 16'd98;
        errors     = 0;
        checks     = 0;
        m_ac       = '0;
        m_e        = 1'b0;
        m_pc       = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_word("busy", 16'd0, word_t'(busy));
        check_word("ac", 16'd0, ac);
        check_word("e", 16'd0, word_t'(e));
        check_word("pc", 16'd0, word_t'(pc));
        // Random fill, written and read back
        for (int a = 0; a < mem_depth; a++) begin
            model_mem[a] = rand_word();
        end
        load_memory();
        verify_memory();
        build_arith(int'(m_pc));
        launch(1'b0, 0);
        build_flow(int'(m_pc));
        launch(1'b0, 0);
        build_regref(int'(m_pc));
        launch(1'b0, 0);
        // Start and host write while busy must be ignored
        build_arith(int'(m_pc));
        launch(1'b1, int'(m_pc) + 'h4F);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verification
src/basic_cpu_pkg.sv
src/control_sequencer.sv
src/cpu_registers.sv
src/accumulator_unit.sv
src/memory_arbiter.sv
src/main_memory.sv
src/basic_cpu.sv
verification/tb_basic_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_basic_cpu
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
